// ==== aluTop.f ====
design/aluCfgPkg.sv
design/aluOpPkg.sv
design/simpleAlu.sv
design/serialDivider.sv
design/intSqrt.sv
design/aluIssue.sv
design/resultFifo.sv
design/aluTop.sv
tb/aluTop_checker.sv
tb/aluTop_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ALU testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aluTop_tb \
    -f aluTop.f -o aluSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/aluSim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -qx "Everything OK" sim.log && exit 0 || exit 1

// ==== tb/aluTop_tb.sv ====
module aluTop_tb;
    import aluCfgPkg::*;
    import aluOpPkg::*;

    // Raw code so that undefined values fit in the table
    typedef struct packed {
        logic [5:0] code;
        aluWord_t   operandA;
        aluWord_t   operandB;
        aluWord_t   expected;
    } tableEntry_t;

    logic Schreibsignal;
    logic i_reset;
    logic i_cmdValid;
    aluCmd_t i_cmd;
    logic i_resReady;
    logic o_cmdReady;
    logic o_resValid;
    aluResult_t o_res;

    tableEntry_t entries[$];
    string entryNames[$];
    logic [15:0] lfsrState;
    int valueErrors;
    int codeErrors;
    int cycleCount;
    int cycleLimit;

    aluTop aluTop_i (
        .Schreibsignal (Schreibsignal),
        .i_reset       (i_reset),
        .i_cmdValid    (i_cmdValid),
        .i_cmd         (i_cmd),
        .i_resReady    (i_resReady),
        .o_cmdReady    (o_cmdReady),
        .o_resValid    (o_resValid),
        .o_res         (o_res)
    );

    always #5 Schreibsignal = ~Schreibsignal;

    // Galois form, polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        lfsrNext = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic addEntry(input string name, input logic [5:0] code, input aluWord_t a,
                            input aluWord_t b, input aluWord_t expected);
        entries.push_back('{code: code, operandA: a, operandB: b, expected: expected});
        entryNames.push_back(name);
    endtask

    task automatic buildTable();
        addEntry("add_basic", FN_ADD, 32'h00000005, 32'h00000007, 32'h0000000C);
        addEntry("add_wrap", FN_ADD, 32'hFFFFFFFF, 32'h00000002, 32'h00000001);
        addEntry("sub_basic", FN_SUB, 32'h00000010, 32'h00000003, 32'h0000000D);
        addEntry("sub_wrap", FN_SUB, 32'h00000000, 32'h00000001, 32'hFFFFFFFF);
        addEntry("mul_low", FN_MUL, 32'h00010000, 32'h00010001, 32'h00010000);
        addEntry("mul_ones", FN_MUL, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000001);
        addEntry("shl_4", FN_SHL, 32'h0000000F, 32'h00000004, 32'h000000F0);
        addEntry("shl_b_high", FN_SHL, 32'h00000001, 32'h00000021, 32'h00000002);
        addEntry("shr_31", FN_SHR, 32'h80000000, 32'h0000001F, 32'h00000001);
        addEntry("shr_b_high", FN_SHR, 32'hF0000000, 32'hFFFFFFE4, 32'h0F000000);
        addEntry("rol_0", FN_ROL, 32'h12345678, 32'h00000000, 32'h12345678);
        addEntry("rol_4", FN_ROL, 32'h12345678, 32'h00000004, 32'h23456781);
        addEntry("rol_31", FN_ROL, 32'h80000001, 32'h0000001F, 32'hC0000000);
        addEntry("ror_0", FN_ROR, 32'hDEADBEEF, 32'h00000020, 32'hDEADBEEF);
        addEntry("ror_8", FN_ROR, 32'h12345678, 32'h00000008, 32'h78123456);
        addEntry("ror_31", FN_ROR, 32'h80000001, 32'h0000001F, 32'h00000003);
        addEntry("eq_true", FN_EQ, 32'hA5A5A5A5, 32'hA5A5A5A5, 32'h00000001);
        addEntry("eq_false", FN_EQ, 32'h00000001, 32'h80000001, 32'h00000000);
        addEntry("ne_false", FN_NE, 32'h00000007, 32'h00000007, 32'h00000000);
        addEntry("ne_true", FN_NE, 32'h00000007, 32'h00000008, 32'h00000001);
        addEntry("gt_unsigned", FN_GT, 32'h80000000, 32'h7FFFFFFF, 32'h00000001);
        addEntry("gt_equal", FN_GT, 32'h00000010, 32'h00000010, 32'h00000000);
        addEntry("ge_equal", FN_GE, 32'h00000010, 32'h00000010, 32'h00000001);
        addEntry("ge_false", FN_GE, 32'h7FFFFFFF, 32'h80000000, 32'h00000000);
        addEntry("lt_unsigned", FN_LT, 32'hFFFFFFFF, 32'h00000001, 32'h00000000);
        addEntry("lt_true", FN_LT, 32'h00000001, 32'hFFFFFFFF, 32'h00000001);
        addEntry("le_true", FN_LE, 32'h00000003, 32'h00000004, 32'h00000001);
        addEntry("le_equal", FN_LE, 32'h00000005, 32'h00000005, 32'h00000001);
        addEntry("le_false", FN_LE, 32'h80000000, 32'h7FFFFFFF, 32'h00000000);
        addEntry("not", FN_NOT, 32'h0F0F0000, 32'h12345678, 32'hF0F0FFFF);
        addEntry("and", FN_AND, 32'hFF00FF00, 32'h0FF00FF0, 32'h0F000F00);
        addEntry("or", FN_OR, 32'hFF00FF00, 32'h0FF00FF0, 32'hFFF0FFF0);
        addEntry("xor", FN_XOR, 32'hFF00FF00, 32'h0FF00FF0, 32'hF0F0F0F0);
        addEntry("xnor", FN_XNOR, 32'hFF00FF00, 32'h0FF00FF0, 32'h0F0F0F0F);
        addEntry("div_basic", FN_DIV, 32'd100, 32'd7, 32'd14);
        addEntry("mod_basic", FN_MOD, 32'd100, 32'd7, 32'd2);
        addEntry("div_large", FN_DIV, 32'hFFFFFFFF, 32'h00010000, 32'h0000FFFF);
        addEntry("div_zero", FN_DIV, 32'h12345678, 32'h00000000, 32'hFFFFFFFF);
        addEntry("mod_zero", FN_MOD, 32'h12345678, 32'h00000000, 32'h12345678);
        addEntry("sqrt_0", FN_SQRT, 32'd0, 32'd0, 32'd0);
        addEntry("sqrt_99", FN_SQRT, 32'd99, 32'd0, 32'd9);
        addEntry("sqrt_max", FN_SQRT, 32'hFFFFFFFF, 32'd0, 32'h0000FFFF);
        addEntry("undef_0a", 6'h0A, 32'h00000005, 32'h00000007, 32'h00000000);
        addEntry("undef_float", 6'h20, 32'h3F800000, 32'h40000000, 32'h00000000);
        addEntry("undef_3f", 6'h3F, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000000);
    endtask

    task automatic checkEqual(input string testName, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual, output bit mismatch);
        mismatch = (expected !== actual);
        if (mismatch) begin
            $display("ERR %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic driveCommands();
        foreach (entries[i]) begin
            @(posedge Schreibsignal);
            i_cmdValid <= 1'b1;
            i_cmd <= '{func: aluFunc_t'(entries[i].code),
                       operandA: entries[i].operandA,
                       operandB: entries[i].operandB};
            // Ready seen here means the command moves on the coming edge
            @(negedge Schreibsignal);
            while (!o_cmdReady) begin
                @(negedge Schreibsignal);
            end
        end
        @(posedge Schreibsignal);
        i_cmdValid <= 1'b0;
    endtask

    task automatic collectResults();
        int index;
        bit valueBad;
        bit codeBad;
        index = 0;
        while (index < entries.size()) begin
            @(posedge Schreibsignal);
            lfsrState = lfsrNext(lfsrState);
            i_resReady <= lfsrState[0];
            @(negedge Schreibsignal);
            if (o_resValid && i_resReady) begin
                checkEqual({entryNames[index], " result"}, entries[index].expected,
                           o_res.result, valueBad);
                checkEqual({entryNames[index], " code"}, 32'(entries[index].code),
                           32'(o_res.func), codeBad);
                if (valueBad) begin
                    valueErrors++;
                end
                if (codeBad) begin
                    codeErrors++;
                end
                index++;
            end
        end
        @(posedge Schreibsignal);
        i_resReady <= 1'b0;
    endtask

    // Run limit grows with the number of table entries
    always @(posedge Schreibsignal) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, not every result arrived", cycleCount);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        Schreibsignal = 1'b0;
        i_reset = 1'b1;
        i_cmdValid = 1'b0;
        i_cmd = '0;
        i_resReady = 1'b0;
        lfsrState = 16'd52;
        valueErrors = 0;
        codeErrors = 0;
        cycleCount = 0;
        cycleLimit = 0;
        buildTable();
        cycleLimit = entries.size() * 40 + 200;
        repeat (16) @(posedge Schreibsignal);
        i_reset <= 1'b0;
        fork
            driveCommands();
            collectResults();
        join
        $display("Errors: %0d wrong values, %0d wrong codes", valueErrors, codeErrors);
        if (valueErrors + codeErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== tb/aluTop_checker.sv ====
module aluTop_checker (
    input logic                 Schreibsignal,
    input logic                 i_reset,
    input logic                 i_cmdValid,
    input logic                 i_cmdReady,
    input aluOpPkg::aluCmd_t    i_issueCmd,
    input logic                 i_resValid,
    input logic                 i_resReady,
    input aluOpPkg::aluResult_t i_res
);

    // Head result stays put until the consumer takes it
    resultHeld: assert property (@(posedge Schreibsignal) disable iff (i_reset)
        i_resValid && !i_resReady |=> i_resValid && $stable(i_res))
        else $error("Result changed or dropped while the consumer was stalling");

    resetQuiet: assert property (@(posedge Schreibsignal) i_reset |=> !i_resValid)
        else $error("Result valid went high during reset");

    // Issue stage latches a command only on a real transfer
    noStalledAccept: assert property (@(posedge Schreibsignal) disable iff (i_reset)
        i_cmdValid && !i_cmdReady |=> $stable(i_issueCmd))
        else $error("Command was taken while command ready was low");

endmodule

bind aluTop aluTop_checker aluTop_checker_i (
    .Schreibsignal (Schreibsignal),
    .i_reset       (i_reset),
    .i_cmdValid    (i_cmdValid),
    .i_cmdReady    (o_cmdReady),
    .i_issueCmd    (aluIssue_i.cmdReg),
    .i_resValid    (o_resValid),
    .i_resReady    (i_resReady),
    .i_res         (o_res)
);

// ==== design/aluTop.sv ====
module aluTop (
    input  logic                 Schreibsignal,
    input  logic                 i_reset,
    input  logic                 i_cmdValid,
    input  aluOpPkg::aluCmd_t    i_cmd,
    input  logic                 i_resReady,
    output logic                 o_cmdReady,
    output logic                 o_resValid,
    output aluOpPkg::aluResult_t o_res
);
    import aluOpPkg::*;

    // Issue stage output slot into the result buffer
    logic issueValid;
    logic issueReady;
    aluResult_t issueResult;

    aluIssue aluIssue_i (
        .Schreibsignal (Schreibsignal),
        .i_reset       (i_reset),
        .i_cmdValid    (i_cmdValid),
        .i_cmd         (i_cmd),
        .i_resReady    (issueReady),
        .o_cmdReady    (o_cmdReady),
        .o_resValid    (issueValid),
        .o_res         (issueResult)
    );

    resultFifo resultFifo_i (
        .Schreibsignal (Schreibsignal),
        .i_reset       (i_reset),
        .i_wrValid     (issueValid),
        .i_wrData      (issueResult),
        .i_rdReady     (i_resReady),
        .o_wrReady     (issueReady),
        .o_rdValid     (o_resValid),
        .o_rdData      (o_res)
    );

endmodule

// ==== design/resultFifo.sv ====
module resultFifo (
    input  logic                 Schreibsignal,
    input  logic                 i_reset,
    input  logic                 i_wrValid,
    input  aluOpPkg::aluResult_t i_wrData,
    input  logic                 i_rdReady,
    output logic                 o_wrReady,
    output logic                 o_rdValid,
    output aluOpPkg::aluResult_t o_rdData
);
    import aluCfgPkg::*;
    import aluOpPkg::*;

    aluResult_t entries [RESULT_FIFO_DEPTH];
    logic [$clog2(RESULT_FIFO_DEPTH)-1:0] wrPtr;
    logic [$clog2(RESULT_FIFO_DEPTH)-1:0] rdPtr;
    logic [$clog2(RESULT_FIFO_DEPTH+1)-1:0] count;
    logic doWrite;
    logic doRead;

    // Head entry is visible without a read request
    assign o_rdValid = (count != '0);
    assign o_rdData = entries[rdPtr];
    // A full buffer still takes a write when the head leaves in the same cycle
    assign o_wrReady = (count != RESULT_FIFO_DEPTH) || i_rdReady;
    assign doWrite = i_wrValid && o_wrReady;
    assign doRead = o_rdValid && i_rdReady;

    always_ff @(posedge Schreibsignal) begin
        if (i_reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == RESULT_FIFO_DEPTH - 1) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == RESULT_FIFO_DEPTH - 1) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge Schreibsignal) begin
        if (doWrite) begin
            entries[wrPtr] <= i_wrData;
        end
    end

endmodule

// ==== design/aluIssue.sv ====
module aluIssue (
    input  logic                 Schreibsignal,
    input  logic                 i_reset,
    input  logic                 i_cmdValid,
    input  aluOpPkg::aluCmd_t    i_cmd,
    input  logic                 i_resReady,
    output logic                 o_cmdReady,
    output logic                 o_resValid,
    output aluOpPkg::aluResult_t o_res
);
    import aluOpPkg::*;

    typedef enum logic [1:0] {
        ISSUE_IDLE,
        ISSUE_WAIT_DIV,
        ISSUE_WAIT_SQRT
    } issueState_t;

    issueState_t state;
    aluCmd_t cmdReg;
    logic cmdAccept;
    logic isDivCmd;
    logic isSqrtCmd;
    logic divStart;
    logic divDone;
    logic sqrtStart;
    logic sqrtDone;
    aluWord_t simpleResult;
    aluWord_t quotient;
    aluWord_t remainder;
    aluWord_t root;

    // Take a command only when idle and the slot frees up this cycle
    assign o_cmdReady = (state == ISSUE_IDLE) && (!o_resValid || i_resReady);
    assign cmdAccept = i_cmdValid && o_cmdReady;
    assign isDivCmd = (i_cmd.func == FN_DIV) || (i_cmd.func == FN_MOD);
    assign isSqrtCmd = (i_cmd.func == FN_SQRT);

    always_ff @(posedge Schreibsignal) begin
        if (i_reset) begin
            state <= ISSUE_IDLE;
            o_resValid <= 1'b0;
            divStart <= 1'b0;
            sqrtStart <= 1'b0;
        end else begin
            divStart <= 1'b0;
            sqrtStart <= 1'b0;
            if (o_resValid && i_resReady) begin
                o_resValid <= 1'b0;
            end
            case (state)
                ISSUE_IDLE: begin
                    if (cmdAccept && isDivCmd) begin
                        state <= ISSUE_WAIT_DIV;
                        divStart <= 1'b1;
                    end else if (cmdAccept && isSqrtCmd) begin
                        state <= ISSUE_WAIT_SQRT;
                        sqrtStart <= 1'b1;
                    end else if (cmdAccept) begin
                        o_resValid <= 1'b1;
                    end
                end
                ISSUE_WAIT_DIV: begin
                    if (divDone) begin
                        state <= ISSUE_IDLE;
                        o_resValid <= 1'b1;
                    end
                end
                ISSUE_WAIT_SQRT: begin
                    if (sqrtDone) begin
                        state <= ISSUE_IDLE;
                        o_resValid <= 1'b1;
                    end
                end
                default: state <= ISSUE_IDLE;
            endcase
        end
    end

    // Command and output slot payload
    always_ff @(posedge Schreibsignal) begin
        if (cmdAccept) begin
            cmdReg <= i_cmd;
        end
        if (cmdAccept && !isDivCmd && !isSqrtCmd) begin
            o_res <= '{func: i_cmd.func, result: simpleResult};
        end else if (divDone) begin
            o_res <= '{func: cmdReg.func,
                       result: (cmdReg.func == FN_MOD) ? remainder : quotient};
        end else if (sqrtDone) begin
            o_res <= '{func: cmdReg.func, result: root};
        end
    end

    simpleAlu simpleAlu_i (
        .i_func     (i_cmd.func),
        .i_operandA (i_cmd.operandA),
        .i_operandB (i_cmd.operandB),
        .o_result   (simpleResult)
    );

    // Long units read the latched command
    serialDivider serialDivider_i (
        .Schreibsignal (Schreibsignal),
        .i_reset       (i_reset),
        .i_start       (divStart),
        .i_dividend    (cmdReg.operandA),
        .i_divisor     (cmdReg.operandB),
        .o_done        (divDone),
        .o_quotient    (quotient),
        .o_remainder   (remainder)
    );

    intSqrt intSqrt_i (
        .Schreibsignal (Schreibsignal),
        .i_reset       (i_reset),
        .i_start       (sqrtStart),
        .i_radicand    (cmdReg.operandA),
        .o_done        (sqrtDone),
        .o_root        (root)
    );

endmodule

// ==== design/intSqrt.sv ====
module intSqrt (
    input  logic               Schreibsignal,
    input  logic               i_reset,
    input  logic               i_start,
    input  aluOpPkg::aluWord_t i_radicand,
    output logic               o_done,
    output aluOpPkg::aluWord_t o_root
);
    import aluCfgPkg::*;
    import aluOpPkg::*;

    typedef enum logic [1:0] {
        SQRT_IDLE,
        SQRT_RUN,
        SQRT_DONE
    } sqrtState_t;

    sqrtState_t state;
    logic [$clog2(SQRT_STEPS)-1:0] stepCount;
    aluWord_t radicand;
    logic [SQRT_STEPS-1:0] root;
    logic [SQRT_STEPS+1:0] partial;
    logic [SQRT_STEPS+1:0] shiftedPartial;
    logic [SQRT_STEPS+1:0] trial;

    // Bring down the next digit pair and try root*4+1
    assign shiftedPartial = {partial[SQRT_STEPS-1:0], radicand[DATA_WIDTH-1 -: 2]};
    assign trial = {root, 2'b01};

    always_ff @(posedge Schreibsignal) begin
        if (i_reset) begin
            state <= SQRT_IDLE;
            stepCount <= '0;
        end else begin
            case (state)
                SQRT_IDLE: begin
                    stepCount <= '0;
                    if (i_start) begin
                        state <= SQRT_RUN;
                    end
                end
                SQRT_RUN: begin
                    stepCount <= stepCount + 1'b1;
                    if (stepCount == SQRT_STEPS - 1) begin
                        state <= SQRT_DONE;
                    end
                end
                default: state <= SQRT_IDLE;
            endcase
        end
    end

    always_ff @(posedge Schreibsignal) begin
        if (state == SQRT_IDLE && i_start) begin
            radicand <= i_radicand;
            root <= '0;
            partial <= '0;
        end else if (state == SQRT_RUN) begin
            radicand <= radicand << 2;
            if (shiftedPartial >= trial) begin
                partial <= shiftedPartial - trial;
                root <= {root[SQRT_STEPS-2:0], 1'b1};
            end else begin
                partial <= shiftedPartial;
                root <= {root[SQRT_STEPS-2:0], 1'b0};
            end
        end
    end

    assign o_done = (state == SQRT_DONE);
    assign o_root = aluWord_t'(root);

endmodule

// ==== design/serialDivider.sv ====
module serialDivider (
    input  logic               Schreibsignal,
    input  logic               i_reset,
    input  logic               i_start,
    input  aluOpPkg::aluWord_t i_dividend,
    input  aluOpPkg::aluWord_t i_divisor,
    output logic               o_done,
    output aluOpPkg::aluWord_t o_quotient,
    output aluOpPkg::aluWord_t o_remainder
);
    import aluCfgPkg::*;
    import aluOpPkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } divState_t;

    divState_t state;
    logic [$clog2(DIV_STEPS)-1:0] stepCount;
    aluWord_t quotient;
    aluWord_t remainder;
    aluWord_t divisor;
    logic [DATA_WIDTH:0] shifted;
    logic [DATA_WIDTH:0] difference;

    // Next dividend bit moves from the quotient register into the remainder
    assign shifted = {remainder, quotient[DATA_WIDTH-1]};
    assign difference = shifted - {1'b0, divisor};

    always_ff @(posedge Schreibsignal) begin
        if (i_reset) begin
            state <= DIV_IDLE;
            stepCount <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    stepCount <= '0;
                    if (i_start) begin
                        state <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    stepCount <= stepCount + 1'b1;
                    if (stepCount == DIV_STEPS - 1) begin
                        state <= DIV_DONE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // Zero divisor always subtracts, so all ones and the dividend fall out
    always_ff @(posedge Schreibsignal) begin
        if (state == DIV_IDLE && i_start) begin
            quotient <= i_dividend;
            remainder <= '0;
            divisor <= i_divisor;
        end else if (state == DIV_RUN) begin
            if (shifted >= {1'b0, divisor}) begin
                remainder <= difference[DATA_WIDTH-1:0];
                quotient <= {quotient[DATA_WIDTH-2:0], 1'b1};
            end else begin
                remainder <= shifted[DATA_WIDTH-1:0];
                quotient <= {quotient[DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

    assign o_done = (state == DIV_DONE);
    assign o_quotient = quotient;
    assign o_remainder = remainder;

endmodule

// ==== design/simpleAlu.sv ====
module simpleAlu (
    input  aluOpPkg::aluFunc_t i_func,
    input  aluOpPkg::aluWord_t i_operandA,
    input  aluOpPkg::aluWord_t i_operandB,
    output aluOpPkg::aluWord_t o_result
);
    import aluCfgPkg::*;
    import aluOpPkg::*;

    shiftAmount_t shiftAmount;
    aluWord_t rotLeft;
    aluWord_t rotRight;

    assign shiftAmount = i_operandB[SHIFT_WIDTH-1:0];

    // Rotation from two opposite shifts
    // Amount 0 makes the second shift cover the full width and vanish
    assign rotLeft = (i_operandA << shiftAmount)
                   | (i_operandA >> (DATA_WIDTH - shiftAmount));
    assign rotRight = (i_operandA >> shiftAmount)
                    | (i_operandA << (DATA_WIDTH - shiftAmount));

    always_comb begin
        case (i_func)
            // Arithmetic wraps, multiply keeps the low word
            FN_ADD:  o_result = i_operandA + i_operandB;
            FN_SUB:  o_result = i_operandA - i_operandB;
            FN_MUL:  o_result = i_operandA * i_operandB;

            // Shifts and rotates
            FN_SHL:  o_result = i_operandA << shiftAmount;
            FN_SHR:  o_result = i_operandA >> shiftAmount;
            FN_ROL:  o_result = rotLeft;
            FN_ROR:  o_result = rotRight;

            // Unsigned compares give 1 or 0
            FN_EQ:   o_result = aluWord_t'(i_operandA == i_operandB);
            FN_NE:   o_result = aluWord_t'(i_operandA != i_operandB);
            FN_GT:   o_result = aluWord_t'(i_operandA > i_operandB);
            FN_GE:   o_result = aluWord_t'(i_operandA >= i_operandB);
            FN_LT:   o_result = aluWord_t'(i_operandA < i_operandB);
            FN_LE:   o_result = aluWord_t'(i_operandA <= i_operandB);

            // Bitwise
            FN_NOT:  o_result = ~i_operandA;
            FN_AND:  o_result = i_operandA & i_operandB;
            FN_OR:   o_result = i_operandA | i_operandB;
            FN_XOR:  o_result = i_operandA ^ i_operandB;
            FN_XNOR: o_result = i_operandA ~^ i_operandB;

            // Multi-cycle codes, undefined codes and the float group
            default: o_result = '0;
        endcase
    end

endmodule

// ==== design/aluOpPkg.sv ====
package aluOpPkg;

    typedef logic [aluCfgPkg::DATA_WIDTH-1:0] aluWord_t;
    typedef logic [aluCfgPkg::SHIFT_WIDTH-1:0] shiftAmount_t;

    // Bit 5 set selects the float group, which is not implemented
    typedef enum logic [5:0] {
        FN_ADD  = 6'b000000,
        FN_SUB  = 6'b000001,
        FN_MUL  = 6'b000010,
        FN_SQRT = 6'b000011,
        FN_DIV  = 6'b000100,
        FN_MOD  = 6'b000101,
        FN_SHL  = 6'b000110,
        FN_SHR  = 6'b000111,
        FN_ROL  = 6'b001000,
        FN_ROR  = 6'b001001,
        FN_EQ   = 6'b010000,
        FN_NE   = 6'b010001,
        FN_GT   = 6'b010010,
        FN_GE   = 6'b010011,
        FN_LT   = 6'b010100,
        FN_LE   = 6'b010101,
        FN_NOT  = 6'b011000,
        FN_AND  = 6'b011001,
        FN_OR   = 6'b011010,
        FN_XOR  = 6'b011011,
        FN_XNOR = 6'b011100
    } aluFunc_t;

    typedef struct packed {
        aluFunc_t func;
        aluWord_t operandA;
        aluWord_t operandB;
    } aluCmd_t;

    // Result tagged with the code of the command that produced it
    typedef struct packed {
        aluFunc_t func;
        aluWord_t result;
    } aluResult_t;

endpackage

// ==== design/aluCfgPkg.sv ====
package aluCfgPkg;

    // Operand and result width
    localparam int DATA_WIDTH = 32;

    // Low bits of operand B that give the shift or rotate amount
    localparam int SHIFT_WIDTH = 5;

    // Result entries held between issue stage and consumer
    localparam int RESULT_FIFO_DEPTH = 4;

    // One quotient bit per iteration
    localparam int DIV_STEPS = 32;

    // One root bit per iteration, two radicand bits consumed each time
    localparam int SQRT_STEPS = 16;

endpackage
